// ==== source/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// widths shared by the memory-access stage

// data word, also address and hi/lo width
`define MEM_DATA_W  32

// register file address
`define MEM_RADDR_W 5

// stage opcode, same width as the alu opcode bus
`define MEM_OP_W    8

// byte lane select, one bit per byte
// big-endian order, so bit 3 is the lowest byte address
// and that lane carries the most significant byte
`define MEM_SEL_W   4

`endif

// ==== source/mem_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

    // stage opcodes
    // values not listed here are plain alu ops with no memory access
    typedef enum logic [`MEM_OP_W-1:0] {
        OP_NOP = 8'b0000_0000,
        OP_LB  = 8'b1110_0000,   // load byte, sign extend
        OP_LBU = 8'b1110_0100,   // load byte, zero extend
        OP_LH  = 8'b1110_0001,   // half word, needs 2 byte alignment
        OP_LHU = 8'b1110_0101,
        OP_LW  = 8'b1110_0011,   // full word, needs 4 byte alignment
        OP_LWL = 8'b1110_0010,   // unaligned load, left part
        OP_LWR = 8'b1110_0110,   // unaligned load, right part
        OP_SB  = 8'b1110_1000,
        OP_SH  = 8'b1110_1001,
        OP_SW  = 8'b1110_1011,
        OP_SWL = 8'b1110_1010,   // unaligned store, left part
        OP_SWR = 8'b1110_1110    // unaligned store, right part
    } alu_op_e;

    // data memory port, 70 bits
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] addr;   // byte address
        logic                   we;     // write enable
        logic [`MEM_SEL_W-1:0]  sel;    // lane select, bit 3 = msb lane
        logic [`MEM_DATA_W-1:0] data;   // write data
        logic                   ce;     // chip enable
    } mem_req_t;

    // write-back bundle toward the register file and hi/lo, 104 bits
    typedef struct packed {
        logic [`MEM_RADDR_W-1:0] waddr;   // destination register
        logic                    reg_we;
        logic [`MEM_DATA_W-1:0]  wdata;   // alu result in, load result out
        logic                    hi_we;
        logic                    lo_we;
        logic [`MEM_DATA_W-1:0]  hi;
        logic [`MEM_DATA_W-1:0]  lo;
    } wb_t;

    // memory words are big-endian
    //   byte addr  0b00  0b01  0b10  0b11
    //   word bits  31:24 23:16 15:8  7:0
    // the lowest address always holds the msb of the word
    // register bits 31:24 are the msb whatever the memory order

endpackage

`default_nettype wire

// ==== source/load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module load_unit (
    input  mem_pkg::alu_op_e        aluop_i,      // stage opcode
    input  logic [`MEM_DATA_W-1:0]  mem_addr_i,   // effective address
    input  logic [`MEM_DATA_W-1:0]  reg2_data_i,  // rt, kept bytes for lwl/lwr
    input  logic [`MEM_DATA_W-1:0]  mem_data_i,   // read word, same cycle
    input  mem_pkg::wb_t            wb_i,         // wdata holds the alu result
    output mem_pkg::mem_req_t       ld_req_o,
    output mem_pkg::wb_t            wb_o
);
    import mem_pkg::*;

    logic [1:0]             offset;     // byte offset inside the word
    logic [4:0]             sh_up;      // 8 * offset
    logic [4:0]             sh_dn;      // 8 * (3 - offset)
    logic [`MEM_DATA_W-1:0] rd_dn;      // addressed byte moved to bits 7:0
    logic [7:0]             rd_byte;
    logic [15:0]            rd_half;
    logic [`MEM_SEL_W-1:0]  byte_sel;   // one-hot lane for lb/lbu
    logic [`MEM_SEL_W-1:0]  half_sel;
    logic [`MEM_DATA_W-1:0] aligned;    // word address for lwl/lwr
    logic [`MEM_DATA_W-1:0] lwl_keep;   // rt bits that lwl leaves alone
    logic [`MEM_DATA_W-1:0] lwr_keep;
    logic [`MEM_DATA_W-1:0] lwl_word;
    logic [`MEM_DATA_W-1:0] lwr_word;

    assign offset   = mem_addr_i[1:0];
    assign sh_up    = {offset, 3'b000};
    assign sh_dn    = {~offset, 3'b000};
    assign aligned  = {mem_addr_i[`MEM_DATA_W-1:2], 2'b00};

    // offset 0 is the msb lane in big-endian
    assign rd_dn    = mem_data_i >> sh_dn;
    assign rd_byte  = rd_dn[7:0];
    assign rd_half  = offset[1] ? mem_data_i[15:0] : mem_data_i[31:16];
    assign byte_sel = 4'b1000 >> offset;
    assign half_sel = offset[1] ? 4'b0011 : 4'b1100;

    // lwl: memory bytes from the offset onward fill rt from the top
    assign lwl_keep = ~({`MEM_DATA_W{1'b1}} << sh_up);
    assign lwl_word = (mem_data_i << sh_up) | (reg2_data_i & lwl_keep);

    // lwr: memory bytes up to the offset fill rt from the bottom
    assign lwr_keep = ~({`MEM_DATA_W{1'b1}} >> sh_dn);
    assign lwr_word = (mem_data_i >> sh_dn) | (reg2_data_i & lwr_keep);

    always_comb begin
        // default is no access, write-back passes through
        ld_req_o      = '0;
        ld_req_o.addr = mem_addr_i;
        wb_o          = wb_i;

        case (aluop_i)
            OP_LB: begin
                ld_req_o.ce  = 1'b1;
                ld_req_o.sel = byte_sel;
                wb_o.wdata   = {{24{rd_byte[7]}}, rd_byte};
            end
            OP_LBU: begin
                ld_req_o.ce  = 1'b1;
                ld_req_o.sel = byte_sel;
                wb_o.wdata   = {24'b0, rd_byte};
            end
            OP_LH: begin
                ld_req_o.ce = 1'b1;   // enabled even when misaligned
                if (!offset[0]) begin
                    ld_req_o.sel = half_sel;
                    wb_o.wdata   = {{16{rd_half[15]}}, rd_half};
                end else begin
                    wb_o.wdata   = '0;   // odd address, no lanes, zero result
                end
            end
            OP_LHU: begin
                ld_req_o.ce = 1'b1;
                if (!offset[0]) begin
                    ld_req_o.sel = half_sel;
                    wb_o.wdata   = {16'b0, rd_half};
                end else begin
                    wb_o.wdata   = '0;
                end
            end
            OP_LW: begin
                ld_req_o.ce = 1'b1;
                if (offset == 2'b00) begin
                    ld_req_o.sel = 4'b1111;
                    wb_o.wdata   = mem_data_i;
                end else begin
                    wb_o.wdata   = '0;   // misaligned word reads as zero
                end
            end
            OP_LWL: begin
                ld_req_o.ce   = 1'b1;
                ld_req_o.addr = aligned;   // whole word fetched
                ld_req_o.sel  = 4'b1111;
                wb_o.wdata    = lwl_word;
            end
            OP_LWR: begin
                ld_req_o.ce   = 1'b1;
                ld_req_o.addr = aligned;
                ld_req_o.sel  = 4'b1111;
                wb_o.wdata    = lwr_word;
            end
            default: ;   // stores and alu ops, nothing to load
        endcase
    end

endmodule

`default_nettype wire

// ==== source/store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module store_unit (
    input  mem_pkg::alu_op_e        aluop_i,      // stage opcode
    input  logic [`MEM_DATA_W-1:0]  mem_addr_i,   // effective address
    input  logic [`MEM_DATA_W-1:0]  reg2_data_i,  // rt, the store data
    input  mem_pkg::mem_req_t       ld_req_i,     // request from the load path
    output mem_pkg::mem_req_t       mem_req_o     // to data memory
);
    import mem_pkg::*;

    logic [1:0]             offset;     // byte offset inside the word
    logic [4:0]             sh_up;      // 8 * offset
    logic [4:0]             sh_dn;      // 8 * (3 - offset)
    logic [`MEM_DATA_W-1:0] aligned;
    logic [`MEM_DATA_W-1:0] swl_data;
    logic [`MEM_DATA_W-1:0] swr_data;
    logic [`MEM_SEL_W-1:0]  swl_sel;
    logic [`MEM_SEL_W-1:0]  swr_sel;
    mem_req_t               st_base;    // fields common to every store

    assign offset  = mem_addr_i[1:0];
    assign sh_up   = {offset, 3'b000};
    assign sh_dn   = {~offset, 3'b000};
    assign aligned = {mem_addr_i[`MEM_DATA_W-1:2], 2'b00};

    // swl writes the top bytes of rt from the offset to the word end
    assign swl_data = reg2_data_i >> sh_up;
    assign swl_sel  = 4'b1111 >> offset;

    // swr writes the low bytes of rt from the word start up to the offset
    assign swr_data = reg2_data_i << sh_dn;
    assign swr_sel  = 4'b1111 << ~offset;

    always_comb begin
        st_base      = '0;
        st_base.addr = mem_addr_i;
        st_base.we   = 1'b1;
        st_base.ce   = 1'b1;
    end

    always_comb begin
        mem_req_o = ld_req_i;   // loads and alu ops go straight through

        case (aluop_i)
            OP_SB: begin
                mem_req_o      = st_base;
                mem_req_o.data = {4{reg2_data_i[7:0]}};   // byte on every lane
                mem_req_o.sel  = 4'b1000 >> offset;
            end
            OP_SH: begin
                mem_req_o      = st_base;
                mem_req_o.data = {2{reg2_data_i[15:0]}};
                case (offset)
                    2'b00:   mem_req_o.sel = 4'b1100;   // upper half, lower address
                    2'b10:   mem_req_o.sel = 4'b0011;
                    default: mem_req_o.sel = 4'b0000;   // odd, we stays high
                endcase
            end
            OP_SW: begin
                mem_req_o      = st_base;
                mem_req_o.data = reg2_data_i;
                if (offset == 2'b00) begin
                    mem_req_o.sel = 4'b1111;
                end
            end
            OP_SWL: begin
                mem_req_o      = st_base;
                mem_req_o.addr = aligned;
                mem_req_o.data = swl_data;
                mem_req_o.sel  = swl_sel;
            end
            OP_SWR: begin
                mem_req_o      = st_base;
                mem_req_o.addr = aligned;
                mem_req_o.data = swr_data;
                mem_req_o.sel  = swr_sel;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mem_wb_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic          clk,
    input  logic          rst_n_i,   // async, active low
    input  mem_pkg::wb_t  wb_i,      // combinational write-back of this op
    output mem_pkg::wb_t  wb_o       // registered, one edge later
);

    // one stage of delay, a new op is taken every cycle
    // reset clears all three enables together with the payload
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_i;   // no stall, no flush
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  mem_pkg::alu_op_e        aluop_i,
    input  logic [`MEM_DATA_W-1:0]  mem_addr_i,    // effective address from ex
    input  logic [`MEM_DATA_W-1:0]  reg2_data_i,   // rt value
    input  logic [`MEM_DATA_W-1:0]  mem_data_i,    // memory read word
    input  mem_pkg::wb_t            wb_i,          // wdata is the alu result
    output mem_pkg::mem_req_t       mem_req_o,     // combinational request
    output mem_pkg::wb_t            wb_o           // to write-back stage
);
    import mem_pkg::*;

    mem_req_t ld_req;    // load path request, overridden by stores
    wb_t      wb_comb;   // write-back before the pipeline register

    // load lanes, extension and lwl/lwr merge
    load_unit u_load (
        .aluop_i     (aluop_i),
        .mem_addr_i  (mem_addr_i),
        .reg2_data_i (reg2_data_i),
        .mem_data_i  (mem_data_i),
        .wb_i        (wb_i),
        .ld_req_o    (ld_req),
        .wb_o        (wb_comb)
    );

    // store lanes and final request mux
    store_unit u_store (
        .aluop_i     (aluop_i),
        .mem_addr_i  (mem_addr_i),
        .reg2_data_i (reg2_data_i),
        .ld_req_i    (ld_req),
        .mem_req_o   (mem_req_o)
    );

    mem_wb_reg u_mem_wb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (wb_comb),
        .wb_o        (wb_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mem_ref.svh ====
`ifndef TB_MEM_REF_SVH
`define TB_MEM_REF_SVH

// byte idx is the byte address in the word, idx 0 is the msb (big-endian)
function automatic logic [7:0] get_byte(input logic [31:0] w, input int idx);
    return w[(3 - idx) * 8 +: 8];
endfunction

function automatic logic [31:0] put_byte(input logic [31:0] w, input int idx,
                                         input logic [7:0] b);
    logic [31:0] r;
    r = w;
    r[(3 - idx) * 8 +: 8] = b;
    return r;
endfunction

// expected memory port for one op
function automatic mem_req_t ref_req(input alu_op_e op, input logic [31:0] addr,
                                     input logic [31:0] rt);
    mem_req_t r;
    int       k;
    int       i;
    r      = '0;
    r.addr = addr;
    k      = int'(addr[1:0]);
    case (op)
        OP_LB, OP_LBU: begin
            r.ce         = 1'b1;
            r.sel[3 - k] = 1'b1;   // one lane, lowest address on bit 3
        end
        OP_LH, OP_LHU: begin
            r.ce = 1'b1;   // ce stays up when misaligned
            if (k % 2 == 0) begin
                r.sel[3 - k] = 1'b1;
                r.sel[2 - k] = 1'b1;
            end
        end
        OP_LW: begin
            r.ce = 1'b1;
            if (k == 0) r.sel = 4'b1111;
        end
        OP_LWL, OP_LWR: begin
            r.ce        = 1'b1;
            r.addr[1:0] = 2'b00;   // whole aligned word
            r.sel       = 4'b1111;
        end
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR: begin
            r.ce = 1'b1;
            r.we = 1'b1;
            case (op)
                OP_SB: begin
                    for (i = 0; i < 4; i++) r.data = put_byte(r.data, i, rt[7:0]);
                    r.sel[3 - k] = 1'b1;
                end
                OP_SH: begin
                    // low half of rt on both halves
                    for (i = 0; i < 4; i++) begin
                        r.data = put_byte(r.data, i, get_byte(rt, 2 + i % 2));
                    end
                    if (k % 2 == 0) begin
                        r.sel[3 - k] = 1'b1;
                        r.sel[2 - k] = 1'b1;
                    end
                end
                OP_SW: begin
                    r.data = rt;
                    if (k == 0) r.sel = 4'b1111;
                end
                OP_SWL: begin
                    r.addr[1:0] = 2'b00;
                    // rt from its msb onward, into addresses k..3
                    for (i = k; i < 4; i++) begin
                        r.data       = put_byte(r.data, i, get_byte(rt, i - k));
                        r.sel[3 - i] = 1'b1;
                    end
                end
                default: begin   // swr
                    r.addr[1:0] = 2'b00;
                    // rt bytes ending at its lsb, into addresses 0..k
                    for (i = 0; i <= k; i++) begin
                        r.data       = put_byte(r.data, i, get_byte(rt, 3 - k + i));
                        r.sel[3 - i] = 1'b1;
                    end
                end
            endcase
        end
        default: ;   // alu op, port idle
    endcase
    return r;
endfunction

// expected write-back bundle before the register
function automatic wb_t ref_wb(input alu_op_e op, input logic [31:0] addr,
                               input logic [31:0] rt, input logic [31:0] mem,
                               input wb_t wb_in);
    wb_t         w;
    int          k;
    int          i;
    logic [7:0]  b;
    logic [15:0] h;
    w = wb_in;
    k = int'(addr[1:0]);
    b = get_byte(mem, k);
    h = {get_byte(mem, k & 2), get_byte(mem, (k & 2) + 1)};
    case (op)
        OP_LB:  w.wdata = {{24{b[7]}}, b};
        OP_LBU: w.wdata = {24'h0, b};
        OP_LH:  w.wdata = (k % 2 == 0) ? {{16{h[15]}}, h} : 32'h0;
        OP_LHU: w.wdata = (k % 2 == 0) ? {16'h0, h} : 32'h0;
        OP_LW:  w.wdata = (k == 0) ? mem : 32'h0;
        OP_LWL: begin
            w.wdata = rt;
            for (i = k; i < 4; i++) w.wdata = put_byte(w.wdata, i - k, get_byte(mem, i));
        end
        OP_LWR: begin
            w.wdata = rt;
            for (i = 0; i <= k; i++) w.wdata = put_byte(w.wdata, 3 - k + i, get_byte(mem, i));
        end
        default: ;   // stores and alu ops keep the alu result
    endcase
    return w;
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int RST_CYCLES = 10;
    localparam int RAND_OPS   = 600;
    // reset + 176 directed + 600 random ops + drains, about doubled
    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   rst_n;
    alu_op_e                aluop;
    logic [`MEM_DATA_W-1:0] mem_addr;
    logic [`MEM_DATA_W-1:0] reg2_data;
    logic [`MEM_DATA_W-1:0] mem_data;
    wb_t                    wb_in;
    mem_req_t               mem_req;
    wb_t                    wb_out;

    logic [31:0] lfsr_state;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          test_chk0;   // counts at start of current test
    int          test_err0;
    int          cycles;

    logic     op_valid;   // op on the inputs is to be checked
    string    cur_name;
    mem_req_t cur_req;
    wb_t      cur_wb;
    wb_t      wb_q[$];    // wb expected one edge later
    string    wb_name_q[$];

    `include "tb_mem_ref.svh"

    mem_stage uut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .aluop_i     (aluop),
        .mem_addr_i  (mem_addr),
        .reg2_data_i (reg2_data),
        .mem_data_i  (mem_data),
        .wb_i        (wb_in),
        .mem_req_o   (mem_req),
        .wb_o        (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            r          = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic wb_t random_wb();
        wb_t         w;
        logic [31:0] t;
        t        = rand_bits(8);
        w.waddr  = t[4:0];
        w.reg_we = t[5];
        w.hi_we  = t[6];
        w.lo_we  = t[7];
        w.wdata  = rand_bits(32);   // alu result
        w.hi     = rand_bits(32);
        w.lo     = rand_bits(32);
        return w;
    endfunction

    function automatic alu_op_e op_by_index(input int idx);
        case (idx)
            0:  return OP_LB;
            1:  return OP_LBU;
            2:  return OP_LH;
            3:  return OP_LHU;
            4:  return OP_LW;
            5:  return OP_LWL;
            6:  return OP_LWR;
            7:  return OP_SB;
            8:  return OP_SH;
            9:  return OP_SW;
            10: return OP_SWL;
            11: return OP_SWR;
            default: return OP_NOP;
        endcase
    endfunction

    function automatic bit is_mem_op(input logic [7:0] v);
        int i;
        for (i = 0; i < 12; i++) begin
            if (v == op_by_index(i)) return 1'b1;
        end
        return 1'b0;
    endfunction

    // any code outside the load/store set
    function automatic alu_op_e random_alu_op();
        logic [31:0] v;
        v = rand_bits(8);
        while (is_mem_op(v[7:0])) v = rand_bits(8);
        return alu_op_e'(v[7:0]);
    endfunction

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s mem_req: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s wb: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one op per call, expectations ride along with the inputs
    task automatic issue(input string name, input alu_op_e op, input logic [31:0] addr,
                         input logic [31:0] rt, input logic [31:0] mem, input wb_t wb);
        @(posedge clk);
        aluop     <= op;
        mem_addr  <= addr;
        reg2_data <= rt;
        mem_data  <= mem;
        wb_in     <= wb;
        op_valid  <= 1'b1;
        cur_name  <= name;
        cur_req   <= ref_req(op, addr, rt);
        cur_wb    <= ref_wb(op, addr, rt, mem, wb);
    endtask

    task automatic issue_rand(input alu_op_e op, input int off);
        logic [31:0] a;
        logic [31:0] rt;
        logic [31:0] mem;
        wb_t         w;
        string       label;
        a   = rand_bits(30);
        rt  = rand_bits(32);
        mem = rand_bits(32);
        w   = random_wb();
        label = (op.name() == "") ? $sformatf("alu_%02h", op) : op.name();
        issue($sformatf("%s off%0d", label, off), op, {a[29:0], off[1:0]}, rt, mem, w);
    endtask

    // idle until every queued wb has been compared
    task automatic end_test(input string name);
        @(posedge clk);
        op_valid <= 1'b0;
        aluop    <= OP_NOP;
        while (wb_q.size() != 0 || op_valid) @(posedge clk);
        n_tests++;
        $display("test %-10s %4d checks, %0d errors", name,
                 n_checks - test_chk0, n_errors - test_err0);
        test_chk0 = n_checks;
        test_err0 = n_errors;
    endtask

    // request checked mid-cycle, wb one edge later from the queue
    always @(negedge clk) begin : compare
        string nm;
        wb_t   exp_wb;
        if (wb_q.size() != 0) begin
            nm     = wb_name_q.pop_front();
            exp_wb = wb_q.pop_front();
            check_wb(nm, exp_wb, wb_out);
        end
        if (op_valid) begin
            check_req(cur_name, cur_req, mem_req);
            wb_q.push_back(cur_wb);
            wb_name_q.push_back(cur_name);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run hung after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int          i;
        int          j;
        int          n;
        int          off;
        logic [31:0] a;
        logic [31:0] t;
        wb_t         w;
        alu_op_e     op;

        rst_n      = 1'b0;
        aluop      = OP_NOP;
        mem_addr   = '0;
        reg2_data  = '0;
        mem_data   = '0;
        wb_in      = '0;
        op_valid   = 1'b0;
        cur_name   = "";
        cur_req    = '0;
        cur_wb     = '0;
        lfsr_state = 32'hb6d4_f04a;
        n_checks   = 0;
        n_errors   = 0;
        n_tests    = 0;
        test_chk0  = 0;
        test_err0  = 0;
        cycles     = 0;

        // nop with busy wb_in, register must stay clear
        for (i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            a = rand_bits(32);
            t = rand_bits(32);
            w = random_wb();
            aluop     <= OP_NOP;
            mem_addr  <= a;
            reg2_data <= t;
            wb_in     <= w;
            @(negedge clk);
            check_wb("reset", '0, wb_out);
            check_req("reset", ref_req(OP_NOP, a, t), mem_req);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_wb("reset release", '0, wb_out);
        end_test("reset");

        for (j = 0; j < 5; j++)
            for (off = 0; off < 4; off++)
                for (n = 0; n < 3; n++) issue_rand(op_by_index(j), off);
        end_test("loads");

        for (j = 5; j < 7; j++)   // lwl, lwr
            for (off = 0; off < 4; off++)
                for (n = 0; n < 3; n++) issue_rand(op_by_index(j), off);
        end_test("partial");

        for (j = 7; j < 12; j++)
            for (off = 0; off < 4; off++)
                for (n = 0; n < 3; n++) issue_rand(op_by_index(j), off);
        end_test("stores");

        issue_rand(OP_NOP, 0);
        for (n = 0; n < 31; n++) begin
            t = rand_bits(2);
            issue_rand(random_alu_op(), int'(t[1:0]));
        end
        end_test("alu");

        for (n = 0; n < RAND_OPS; n++) begin
            t = rand_bits(4);
            if (t < 13) op = op_by_index(int'(t));
            else op = random_alu_op();   // 3 in 16 are plain alu ops
            t = rand_bits(2);
            issue_rand(op, int'(t[1:0]));
        end
        end_test("random");

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
+incdir+tb
source/mem_pkg.sv
source/load_unit.sv
source/store_unit.sv
source/mem_wb_reg.sv
source/mem_stage.sv
tb/tb_mem_stage.sv
